/* common/u1e_pkg.sv */
// u1e control core shared definitions
// host address map, register offsets, reset values and setting addresses
package u1e_pkg;

   localparam int WB_AW = 11;
   localparam int WB_DW = 16;

   // host address seen as slave number plus offset
   typedef struct packed {
      logic [3:0] slave;
      logic [6:0] offset;
   } wb_slave_addr_t;

   // host address seen by the 16-bit settings and readback slaves
   typedef struct packed {
      logic [2:0] pair;                       // slave pair, 8/9 for settings
      logic [5:0] reg_num;                    // 32-bit register number
      logic       half;                       // 0 low half, 1 high half
      logic       byte_sel;
   } wb_setting_addr_t;

   typedef union packed {
      wb_slave_addr_t   slave;
      wb_setting_addr_t setting;
   } wb_addr_u;

   localparam logic [3:0] SLV_MISC     = 4'd0;
   localparam logic [3:0] SLV_READBACK = 4'd7;
   localparam logic [3:0] SLV_SETTINGS = 4'd8;   // also answers on 9

   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_XFER_RATE = 7'd14;
   localparam logic [6:0] REG_COMPAT    = 7'd16;

   localparam logic [7:0]  COMPAT_NUM      = 8'd6;
   localparam logic [15:0] MISC_DEFAULT    = 16'hBEEF;
   localparam logic [15:0] CGEN_CTRL_RESET = 16'd3;   // sync_b and ref_sel high

   localparam int SR_ADDR_W = 8;
   localparam logic [SR_ADDR_W-1:0] SR_TIME64        = 8'd42;
   localparam logic [SR_ADDR_W-1:0] SR_REG_TEST32    = 8'd60;
   localparam logic [SR_ADDR_W-1:0] SR_CLEAR_RX_FIFO = 8'd61;
   localparam logic [SR_ADDR_W-1:0] SR_CLEAR_TX_FIFO = 8'd62;

   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;

endpackage

/* common/wb16_if.sv */
// 16-bit wishbone link between the host decoder and one slave
`timescale 1ns/1ps

interface wb16_if;
   import u1e_pkg::*;

   wb_addr_u          adr;
   logic [WB_DW-1:0]  dat_w;                  // host to slave
   logic [WB_DW-1:0]  dat_r;                  // slave to host
   logic              we;
   logic              stb;                    // already qualified by cyc and select
   logic              ack;

   modport master (
      output adr, dat_w, we, stb,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, we, stb,
      output dat_r, ack
   );

endinterface

/* hdl/wb_intercon.sv */
// single master wishbone decoder
// routes the host strobe to one slave by the top address bits and returns its data and ack
`timescale 1ns/1ps

module wb_intercon (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  u1e_pkg::wb_addr_u          adr_i,
   input  logic [u1e_pkg::WB_DW-1:0]  dat_i,
   input  logic                       we_i,
   input  logic                       stb_i,
   input  logic                       cyc_i,
   output logic [u1e_pkg::WB_DW-1:0]  dat_o,
   output logic                       ack_o,
   wb16_if.master                     misc_o,
   wb16_if.master                     rb_o,
   wb16_if.master                     set_o
);
   import u1e_pkg::*;

   logic             xfer;
   logic             sel_misc, sel_rb, sel_set;
   logic [WB_DW-1:0] rd_data;
   logic [WB_DW-1:0] dat_hold_q;              // last word read by the host

   assign xfer     = cyc_i & stb_i;
   assign sel_misc = (adr_i.slave.slave == SLV_MISC);
   assign sel_rb   = (adr_i.slave.slave == SLV_READBACK);
   assign sel_set  = (adr_i.slave.slave[3:1] == SLV_SETTINGS[3:1]);   // 8 and 9

   ////////////////////////////////////////
   // request side, same fields to every slave
   assign misc_o.adr   = adr_i;
   assign misc_o.dat_w = dat_i;
   assign misc_o.we    = we_i;
   assign misc_o.stb   = xfer & sel_misc;

   assign rb_o.adr     = adr_i;
   assign rb_o.dat_w   = dat_i;
   assign rb_o.we      = we_i;
   assign rb_o.stb     = xfer & sel_rb;

   assign set_o.adr    = adr_i;
   assign set_o.dat_w  = dat_i;
   assign set_o.we     = we_i;
   assign set_o.stb    = xfer & sel_set;

   ////////////////////////////////////////
   // response side
   always_comb
   begin
      if (sel_misc)
         rd_data = misc_o.dat_r;
      else if (sel_rb)
         rd_data = rb_o.dat_r;
      else if (sel_set)
         rd_data = set_o.dat_r;
      else
         rd_data = '0;                        // unmapped slave reads zero
   end

   // only the selected slave sees a strobe, so the acks never overlap
   assign ack_o = misc_o.ack | rb_o.ack | set_o.ack;

   // read data stays on the bus between transfers
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         dat_hold_q <= '0;
      else if (ack_o && !we_i)
         dat_hold_q <= rd_data;
   end

   assign dat_o = xfer ? rd_data : dat_hold_q;

endmodule

/* hdl/misc_regs.sv */
// slave 0, misc control and status registers
// leds, clock generator control and status, test, transfer rate, compat number
`timescale 1ns/1ps

module misc_regs (
   input  logic        wb_clk,
   input  logic        wb_rst,
   wb16_if.slave       bus_i,
   input  logic [2:0]  cgen_st_i,             // status, lock detect, ref monitor
   output logic [15:0] leds_o,
   output logic        cgen_sync_b_o,
   output logic        cgen_ref_sel_o,
   output logic [15:0] xfer_rate_o
);
   import u1e_pkg::*;

   logic [15:0] reg_leds, reg_cgen_ctrl, reg_test, reg_xfer_rate;
   logic [15:0] rd_data;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= CGEN_CTRL_RESET;
         reg_test      <= '0;
         reg_xfer_rate <= '0;
      end
      else if (bus_i.stb && bus_i.we)
      begin
         case (bus_i.adr.slave.offset)
            REG_LEDS      : reg_leds      <= bus_i.dat_w;
            REG_CGEN_CTRL : reg_cgen_ctrl <= bus_i.dat_w;
            REG_TEST      : reg_test      <= bus_i.dat_w;
            REG_XFER_RATE : reg_xfer_rate <= bus_i.dat_w;
            default       : ;                 // read only or unmapped
         endcase
      end
   end

   // xfer_rate has no readback
   always_comb
   begin
      case (bus_i.adr.slave.offset)
         REG_LEDS      : rd_data = reg_leds;
         REG_CGEN_CTRL : rd_data = reg_cgen_ctrl;
         REG_CGEN_ST   : rd_data = {13'd0, cgen_st_i};
         REG_TEST      : rd_data = reg_test;
         REG_COMPAT    : rd_data = {8'd0, COMPAT_NUM};
         default       : rd_data = MISC_DEFAULT;
      endcase
   end

   assign bus_i.dat_r = rd_data;
   assign bus_i.ack   = bus_i.stb;

   assign leds_o                          = reg_leds;
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];
   assign xfer_rate_o                     = reg_xfer_rate;

endmodule

/* settings/settings_bus.sv */
// slaves 8/9, 16-bit little endian settings bus
// a low half write is stored, the high half write fires the 32-bit setting
`timescale 1ns/1ps

module settings_bus (
   input  logic                           wb_clk,
   input  logic                           wb_rst,
   wb16_if.slave                          bus_i,
   output logic                           set_stb_o,
   output logic [u1e_pkg::SR_ADDR_W-1:0]  set_addr_o,
   output logic [31:0]                    set_data_o
);
   import u1e_pkg::*;

   logic        wr;
   logic [15:0] low_q;                        // pending low half

   assign wr = bus_i.stb & bus_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr & bus_i.adr.setting.half;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr && !bus_i.adr.setting.half)
         low_q <= bus_i.dat_w;
      if (wr && bus_i.adr.setting.half)
      begin
         set_addr_o <= {2'b00, bus_i.adr.setting.reg_num};
         set_data_o <= {bus_i.dat_w, low_q};
      end
   end

   assign bus_i.dat_r = '0;                   // write only
   assign bus_i.ack   = bus_i.stb;

endmodule

/* settings/setting_ctrl.sv */
// test32 setting and fifo clear strobes
// test32 survives reset so software can tell the fpga is still loaded
`timescale 1ns/1ps

module setting_ctrl (
   input  logic                           wb_clk,
   input  logic                           wb_rst,
   input  logic                           set_stb_i,
   input  logic [u1e_pkg::SR_ADDR_W-1:0]  set_addr_i,
   input  logic [31:0]                    set_data_i,
   output logic [31:0]                    test32_o,
   output logic                           clear_rx_o,
   output logic                           clear_tx_o
);
   import u1e_pkg::*;

   logic hit_test32, hit_clear_rx, hit_clear_tx;

   assign hit_test32   = set_stb_i && (set_addr_i == SR_REG_TEST32);
   assign hit_clear_rx = set_stb_i && (set_addr_i == SR_CLEAR_RX_FIFO);
   assign hit_clear_tx = set_stb_i && (set_addr_i == SR_CLEAR_TX_FIFO);

   always_ff @(posedge wb_clk)
   begin
      if (hit_test32)
         test32_o <= set_data_i;
   end

   // one cycle pulse per write, data ignored
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         clear_rx_o <= 1'b0;
         clear_tx_o <= 1'b0;
      end
      else
      begin
         clear_rx_o <= hit_clear_rx;
         clear_tx_o <= hit_clear_tx;
      end
   end

endmodule

/* timing/vita_time.sv */
// 64-bit vita time counter
// loads now or at the next pps, and captures the time at each pps edge
`timescale 1ns/1ps

module vita_time #(
   parameter logic [u1e_pkg::SR_ADDR_W-1:0] SETTING_BASE = u1e_pkg::SR_TIME64
) (
   input  logic                           wb_clk,
   input  logic                           wb_rst,
   input  logic                           set_stb_i,
   input  logic [u1e_pkg::SR_ADDR_W-1:0]  set_addr_i,
   input  logic [31:0]                    set_data_i,
   input  logic                           pps_i,
   output logic [63:0]                    vita_time_o,
   output logic [63:0]                    vita_time_pps_o
);
   import u1e_pkg::*;

   localparam logic [SR_ADDR_W-1:0] ADDR_HI   = SETTING_BASE;
   localparam logic [SR_ADDR_W-1:0] ADDR_LO   = SETTING_BASE + 8'd1;
   localparam logic [SR_ADDR_W-1:0] ADDR_CTRL = SETTING_BASE + 8'd2;

   logic [31:0] pending_hi, pending_lo;
   logic        ctrl_wr, load_now, armed;
   logic        pps_meta, pps_sync, pps_del, pps_edge;

   assign ctrl_wr  = set_stb_i && (set_addr_i == ADDR_CTRL);
   assign load_now = ctrl_wr && set_data_i[0];

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && set_addr_i == ADDR_HI)
         pending_hi <= set_data_i;
      if (set_stb_i && set_addr_i == ADDR_LO)
         pending_lo <= set_data_i;
   end

   ////////////////////////////////////////
   // pps synchronizer and rise detect
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_del;

   ////////////////////////////////////////
   // time counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed           <= 1'b0;
      end
      else
      begin
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;      // time of the pps edge

         if (load_now || (pps_edge && armed))
            vita_time_o <= {pending_hi, pending_lo};
         else
            vita_time_o <= vita_time_o + 64'd1;

         if (ctrl_wr)
            armed <= ~set_data_i[0];             // bit 0 low waits for pps
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

endmodule

/* hdl/readback_mux.sv */
// slave 7, 32-bit readback words returned as 16-bit halves
`timescale 1ns/1ps

module readback_mux (
   wb16_if.slave        bus_i,
   input  logic [63:0]  vita_time_i,
   input  logic [63:0]  vita_time_pps_i,
   input  logic [31:0]  test32_i
);
   import u1e_pkg::*;

   logic [3:0]  word_idx;
   logic [31:0] word;

   assign word_idx = bus_i.adr.setting.reg_num[3:0];   // address bits 5:2

   always_comb
   begin
      case (word_idx)
         RB_TIME_HI : word = vita_time_i[63:32];
         RB_TIME_LO : word = vita_time_i[31:0];
         RB_PPS_HI  : word = vita_time_pps_i[63:32];
         RB_PPS_LO  : word = vita_time_pps_i[31:0];
         RB_TEST32  : word = test32_i;
         default    : word = '0;               // words 5 to 15 unused
      endcase
   end

   assign bus_i.dat_r = bus_i.adr.setting.half ? word[31:16] : word[15:0];
   assign bus_i.ack   = bus_i.stb;

endmodule

/* hdl/u1e_ctrl_core.sv */
// u1e host control plane
// wishbone host decode, settings bus, setting consumers and readback
`timescale 1ns/1ps

module u1e_ctrl_core (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic [u1e_pkg::WB_AW-1:0]  adr_i,
   input  logic [u1e_pkg::WB_DW-1:0]  dat_i,
   output logic [u1e_pkg::WB_DW-1:0]  dat_o,
   input  logic                       we_i,
   input  logic                       stb_i,
   input  logic                       cyc_i,
   output logic                       ack_o,
   input  logic                       pps_i,
   input  logic [2:0]                 cgen_st_i,
   output logic [15:0]                leds_o,
   output logic                       cgen_sync_b_o,
   output logic                       cgen_ref_sel_o,
   output logic [15:0]                xfer_rate_o,
   output logic                       clear_rx_o,
   output logic                       clear_tx_o
);
   import u1e_pkg::*;

   logic                 set_stb;
   logic [SR_ADDR_W-1:0] set_addr;
   logic [31:0]          set_data;
   logic [31:0]          test32;
   logic [63:0]          vita_time, vita_time_pps;

   wb16_if misc_bus ();
   wb16_if rb_bus ();
   wb16_if set_bus ();

   ////////////////////////////////////////
   // host decode and slaves
   wb_intercon wb_intercon_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .adr_i (adr_i), .dat_i (dat_i), .we_i (we_i), .stb_i (stb_i), .cyc_i (cyc_i),
      .dat_o (dat_o), .ack_o (ack_o),
      .misc_o (misc_bus), .rb_o (rb_bus), .set_o (set_bus)
   );

   misc_regs misc_regs_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus_i (misc_bus), .cgen_st_i (cgen_st_i),
      .leds_o (leds_o), .cgen_sync_b_o (cgen_sync_b_o), .cgen_ref_sel_o (cgen_ref_sel_o),
      .xfer_rate_o (xfer_rate_o)
   );

   settings_bus settings_bus_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus_i (set_bus),
      .set_stb_o (set_stb), .set_addr_o (set_addr), .set_data_o (set_data)
   );

   ////////////////////////////////////////
   // setting consumers and readback
   setting_ctrl setting_ctrl_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .test32_o (test32), .clear_rx_o (clear_rx_o), .clear_tx_o (clear_tx_o)
   );

   vita_time #(.SETTING_BASE (SR_TIME64)) vita_time_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .pps_i (pps_i), .vita_time_o (vita_time), .vita_time_pps_o (vita_time_pps)
   );

   readback_mux readback_mux_i (
      .bus_i (rb_bus), .vita_time_i (vita_time), .vita_time_pps_i (vita_time_pps),
      .test32_i (test32)
   );

endmodule

/* verif/u1e_ctrl_core_assertions.sv */
// bound checks on the host port and the setting strobes
`timescale 1ns/1ps

module u1e_ctrl_core_assertions (
   input logic wb_clk,
   input logic wb_rst,
   input logic stb_i,
   input logic cyc_i,
   input logic ack_i,
   input logic set_stb_i,
   input logic clear_rx_i,
   input logic clear_tx_i
);

   int fail_cnt = 0;                            // failed assertions so far

   // ack is combinational and only answers a live strobe
   ack_needs_stb : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                    ack_i |-> (stb_i && cyc_i))
      else
      begin
         fail_cnt++;
         $error("ack without stb and cyc");
      end

   set_stb_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                     set_stb_i |=> !set_stb_i)
      else
      begin
         fail_cnt++;
         $error("set_stb held for more than one cycle");
      end

   clears_apart : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                   !(clear_rx_i && clear_tx_i))
      else
      begin
         fail_cnt++;
         $error("clear_rx and clear_tx high together");
      end

endmodule

/* verif/tb_u1e_ctrl_core.sv */
// testbench for the u1e host control plane
// random host traffic checked against a register, settings and time model
`timescale 1ns/1ps

module tb_u1e_ctrl_core;
   import u1e_pkg::*;

   localparam int          CLK_PERIOD   = 10;
   localparam logic [31:0] SEED         = 32'd44428;
   localparam int          MAX_XFERS    = 120;      // upper bound over all tests
   localparam int          CYC_PER_XFER = 20;
   localparam logic [6:0]  WR_OFF [4]   = '{REG_LEDS, REG_CGEN_CTRL, REG_TEST, REG_XFER_RATE};

   logic             wb_clk = 1'b0;
   logic             wb_rst;
   logic [WB_AW-1:0] wb_adr;
   logic [WB_DW-1:0] wb_dat_w, wb_dat_r;
   logic             wb_we, wb_stb, wb_cyc, wb_ack;
   logic             pps;
   logic [2:0]       cgen_st;
   logic [15:0]      leds, xfer_rate;
   logic             cgen_sync_b, cgen_ref_sel, clear_rx, clear_tx;

   logic [31:0] lcg_state = SEED;
   logic [63:0] edge_cnt  = '0;
   logic [63:0] xfer_cnt;                       // edge count seen in the last transfer cycle
   logic [63:0] rd_cnt [4];                     // edge count of each readback half
   int          rx_pulses = 0;
   int          tx_pulses = 0;

   // register and time model
   logic [15:0] m_leds, m_ctrl, m_test, m_xfer;
   logic [63:0] time_base, time_base_cnt;

   u1e_ctrl_core u1e_ctrl_core_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .adr_i (wb_adr), .dat_i (wb_dat_w), .dat_o (wb_dat_r),
      .we_i (wb_we), .stb_i (wb_stb), .cyc_i (wb_cyc), .ack_o (wb_ack),
      .pps_i (pps), .cgen_st_i (cgen_st), .leds_o (leds),
      .cgen_sync_b_o (cgen_sync_b), .cgen_ref_sel_o (cgen_ref_sel),
      .xfer_rate_o (xfer_rate), .clear_rx_o (clear_rx), .clear_tx_o (clear_tx)
   );

   bind u1e_ctrl_core u1e_ctrl_core_assertions u1e_ctrl_core_assertions_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .stb_i (stb_i), .cyc_i (cyc_i),
      .ack_i (ack_o), .set_stb_i (set_stb),
      .clear_rx_i (clear_rx_o), .clear_tx_i (clear_tx_o)
   );

   always #(CLK_PERIOD/2) wb_clk = ~wb_clk;

   always @(posedge wb_clk)
      edge_cnt <= edge_cnt + 64'd1;

   always @(negedge wb_clk)
   begin
      if (clear_rx)
         rx_pulses++;
      if (clear_tx)
         tx_pulses++;
   end

   ////////////////////////////////////////
   // helpers
   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [WB_AW-1:0] misc_adr(input logic [6:0] offset);
      return {SLV_MISC, offset};
   endfunction

   // settings register number sits in address bits 7:2, half select in bit 1
   function automatic logic [WB_AW-1:0] set_adr(input logic [SR_ADDR_W-1:0] sr,
                                                input logic half);
      return {SLV_SETTINGS[3:1], sr[5:0], half, 1'b0};
   endfunction

   function automatic logic [WB_AW-1:0] rb_adr(input logic [3:0] idx, input logic half);
      return {SLV_READBACK, 1'b0, idx, half, 1'b0};
   endfunction

   // each half of a counting word is taken at its own read cycle
   function automatic logic [63:0] running_time(input logic [63:0] base,
                                                input logic [63:0] base_cnt);
      logic [63:0] t [4];
      for (int i = 0; i < 4; i++)
         t[i] = base + (rd_cnt[i] - base_cnt);
      return {t[0][63:48], t[1][47:32], t[2][31:16], t[3][15:0]};
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on the first error");
   endtask

   task automatic check_data16(input string name, input logic [WB_DW-1:0] got,
                               input logic [WB_DW-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_time64(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_pulse(input string name, input int got, input int exp);
      if (got != exp)
         fail_run($sformatf("[ERROR] %s pulses: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic apply_reset();
      wb_rst <= 1'b1;
      repeat (4) @(posedge wb_clk);
      wb_rst <= 1'b0;
      m_leds = '0;
      m_ctrl = CGEN_CTRL_RESET;
      m_test = '0;
      m_xfer = '0;
   endtask

   // one classic transfer with the combinational ack sampled mid cycle
   task automatic wb_xfer(input logic [WB_AW-1:0] adr, input logic we,
                          input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
      @(posedge wb_clk);
      wb_adr   <= adr;
      wb_dat_w <= wdata;
      wb_we    <= we;
      wb_stb   <= 1'b1;
      wb_cyc   <= 1'b1;
      @(negedge wb_clk);
      if (wb_ack !== 1'b1)
         fail_run($sformatf("no ack on the host port for address 0x%h", adr));
      rdata    = wb_dat_r;
      xfer_cnt = edge_cnt;
      @(posedge wb_clk);
      wb_stb <= 1'b0;
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdata);
      wb_xfer(adr, 1'b0, '0, rdata);
   endtask

   task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdata);
      logic [WB_DW-1:0] unused;
      wb_xfer(adr, 1'b1, wdata, unused);
   endtask

   task automatic write_setting(input logic [SR_ADDR_W-1:0] sr, input logic [31:0] data);
      wb_write(set_adr(sr, 1'b0), data[15:0]);
      wb_write(set_adr(sr, 1'b1), data[31:16]);   // fires the setting
   endtask

   task automatic read_rb64(input logic [3:0] hi_idx, input logic [3:0] lo_idx,
                            output logic [63:0] got);
      logic [WB_DW-1:0] rd;
      for (int i = 0; i < 4; i++)
      begin
         wb_read(rb_adr((i < 2) ? hi_idx : lo_idx, ~i[0]), rd);
         got[63-16*i -: 16] = rd;
         rd_cnt[i]          = xfer_cnt;
      end
   endtask

   ////////////////////////////////////////
   // tests
   task automatic check_reset_values();
      logic [15:0] rd;
      logic [6:0]  off;
      cgen_st <= 3'(rand32());
      wb_read(misc_adr(REG_LEDS), rd);
      check_data16("leds", rd, 16'd0);
      wb_read(misc_adr(REG_CGEN_CTRL), rd);
      check_data16("cgen_ctrl", rd, 16'd3);
      wb_read(misc_adr(REG_CGEN_ST), rd);
      check_data16("cgen_st", rd, {13'd0, cgen_st});
      wb_read(misc_adr(REG_TEST), rd);
      check_data16("test", rd, 16'd0);
      wb_read(misc_adr(REG_COMPAT), rd);
      check_data16("compat", rd, 16'd6);
      check_data16("cgen_sync_b_o", 16'(cgen_sync_b), 16'd1);
      check_data16("cgen_ref_sel_o", 16'(cgen_ref_sel), 16'd1);
      repeat (4)
      begin
         off = 7'(rand32());
         while (off inside {REG_LEDS, REG_CGEN_CTRL, REG_CGEN_ST, REG_TEST, REG_COMPAT})
            off = 7'(rand32());
         wb_read(misc_adr(off), rd);
         check_data16("misc unmapped", rd, 16'hBEEF);
      end
   endtask

   task automatic check_misc_writes();
      logic [15:0] rd, data;
      logic [1:0]  sel;
      repeat (16)
      begin
         sel  = 2'(rand32() >> 16);             // low lcg bits repeat every 4 draws
         data = 16'(rand32());
         wb_write(misc_adr(WR_OFF[sel]), data);
         case (sel)
            2'd0    : m_leds = data;
            2'd1    : m_ctrl = data;
            2'd2    : m_test = data;
            default : m_xfer = data;
         endcase
      end
      wb_read(misc_adr(REG_LEDS), rd);
      check_data16("leds", rd, m_leds);
      wb_read(misc_adr(REG_CGEN_CTRL), rd);
      check_data16("cgen_ctrl", rd, m_ctrl);
      wb_read(misc_adr(REG_TEST), rd);
      check_data16("test", rd, m_test);
      @(negedge wb_clk);
      check_data16("leds_o", leds, m_leds);
      check_data16("xfer_rate_o", xfer_rate, m_xfer);
      check_data16("cgen_sync_b_o", 16'(cgen_sync_b), 16'(m_ctrl[1]));
      check_data16("cgen_ref_sel_o", 16'(cgen_ref_sel), 16'(m_ctrl[0]));
   endtask

   task automatic check_test32();
      logic [31:0] val;
      logic [15:0] lo, hi;
      repeat (4)
      begin
         val = rand32();
         write_setting(SR_REG_TEST32, val);
         wb_read(rb_adr(RB_TEST32, 1'b0), lo);
         wb_read(rb_adr(RB_TEST32, 1'b1), hi);
         check_data16("test32 low", lo, val[15:0]);
         check_data16("test32 high", hi, val[31:16]);
      end
      apply_reset();                            // test32 must survive this
      wb_read(rb_adr(RB_TEST32, 1'b0), lo);
      wb_read(rb_adr(RB_TEST32, 1'b1), hi);
      check_data16("test32 low after reset", lo, val[15:0]);
      check_data16("test32 high after reset", hi, val[31:16]);
   endtask

   task automatic check_clears();
      int n_rx, n_tx, rx_left, tx_left;
      n_rx    = 1 + int'(rand32() % 6);
      n_tx    = 1 + int'(rand32() % 6);
      rx_left = n_rx;
      tx_left = n_tx;
      while (rx_left + tx_left > 0)
      begin
         if (tx_left == 0 || (rx_left > 0 && ((rand32() >> 16) & 32'd1) != 0))
         begin
            write_setting(SR_CLEAR_RX_FIFO, rand32());
            rx_left--;
         end
         else
         begin
            write_setting(SR_CLEAR_TX_FIFO, rand32());
            tx_left--;
         end
      end
      repeat (3) @(posedge wb_clk);             // last pulse ends two edges after the ack
      check_pulse("clear_rx_o", rx_pulses, n_rx);
      check_pulse("clear_tx_o", tx_pulses, n_tx);
   endtask

   task automatic check_time_load();
      logic [63:0] got;
      time_base = {rand32(), rand32()};
      write_setting(SR_TIME64, time_base[63:32]);
      write_setting(SR_TIME64 + 8'd1, time_base[31:0]);
      write_setting(SR_TIME64 + 8'd2, rand32() | 32'd1);   // bit 0 high loads now
      time_base_cnt = xfer_cnt + 64'd2;         // ack edge, then the load edge
      read_rb64(RB_TIME_HI, RB_TIME_LO, got);
      check_time64("vita_time", got, running_time(time_base, time_base_cnt));
      repeat (int'(rand32() % 16)) @(posedge wb_clk);
      read_rb64(RB_TIME_HI, RB_TIME_LO, got);
      check_time64("vita_time", got, running_time(time_base, time_base_cnt));
   endtask

   task automatic check_pps_load();
      logic [63:0] got, loaded, captured, pps_cnt;
      loaded = {rand32(), rand32()};
      write_setting(SR_TIME64, loaded[63:32]);
      write_setting(SR_TIME64 + 8'd1, loaded[31:0]);
      write_setting(SR_TIME64 + 8'd2, rand32() & ~32'd1);  // armed for the next pps
      pps <= 1'b1;
      @(negedge wb_clk);
      pps_cnt = edge_cnt;
      // seen one edge later, detected two edges after that
      captured = time_base + (pps_cnt + 64'd2 - time_base_cnt);
      repeat (4) @(posedge wb_clk);
      pps <= 1'b0;
      read_rb64(RB_PPS_HI, RB_PPS_LO, got);
      check_time64("vita_time_pps", got, captured);
      read_rb64(RB_TIME_HI, RB_TIME_LO, got);
      check_time64("vita_time", got, running_time(loaded, pps_cnt + 64'd3));
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog
   initial
   begin
      wb_rst   <= 1'b1;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      wb_we    <= 1'b0;
      wb_stb   <= 1'b0;
      wb_cyc   <= 1'b0;
      pps      <= 1'b0;
      cgen_st  <= '0;
      apply_reset();
      check_reset_values();
      check_misc_writes();
      check_test32();
      check_clears();
      check_time_load();
      check_pps_load();
      @(negedge wb_clk);                        // let the last edge's assertions settle
      if (u1e_ctrl_core_i.u1e_ctrl_core_assertions_i.fail_cnt == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
         fail_run("a bound assertion failed during the run");
   end

   // a failed bound assertion stops the run one edge later
   always @(posedge wb_clk)
   begin
      if (u1e_ctrl_core_i.u1e_ctrl_core_assertions_i.fail_cnt != 0)
         fail_run("a bound assertion failed during the run");
   end

   initial
   begin
      #(MAX_XFERS * CYC_PER_XFER * CLK_PERIOD);
      fail_run("watchdog timeout, the tests did not finish in time");
   end

endmodule

/* compile.f */
common/u1e_pkg.sv
common/wb16_if.sv
hdl/wb_intercon.sv
hdl/misc_regs.sv
settings/settings_bus.sv
settings/setting_ctrl.sv
timing/vita_time.sv
hdl/readback_mux.sv
hdl/u1e_ctrl_core.sv
verif/u1e_ctrl_core_assertions.sv
verif/tb_u1e_ctrl_core.sv

/* Bender.yml */
package:
  name: u1e_ctrl_core

sources:
  - files:
      - common/u1e_pkg.sv
      - common/wb16_if.sv
      - hdl/wb_intercon.sv
      - hdl/misc_regs.sv
      - settings/settings_bus.sv
      - settings/setting_ctrl.sv
      - timing/vita_time.sv
      - hdl/readback_mux.sv
      - hdl/u1e_ctrl_core.sv
  - target: simulation
    files:
      - verif/u1e_ctrl_core_assertions.sv
      - verif/tb_u1e_ctrl_core.sv
